// File: lsq_defs.svh
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// load/store queue entries
`define LSQ_DEPTH 16

// physical register tag width
`define PREG_W 6

// reorder buffer number width
`define ROB_W 6

// data memory word-address width, 2**DMEM_AW words
`define DMEM_AW 8

`endif

// File: rv32i_types.sv
package rv32i_types;

    // data or address word
    typedef logic [31:0] word_t;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,  // only lw reaches the lsq
        op_store = 7'b0100011,  // only sw reaches the lsq
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_fence = 7'b0001111,
        op_sys   = 7'b1110011
    } opcode_t;

endpackage : rv32i_types

// File: lsq_types.sv
`include "lsq_defs.svh"

package lsq_types;

    import rv32i_types::*;

    localparam int LSQ_IDX_W = $clog2(`LSQ_DEPTH);

    // queue slot number
    typedef logic [LSQ_IDX_W-1:0] lsq_idx_t;

    // one queue slot
    typedef struct packed {
        logic                   valid;
        logic                   addr_ready;     // agu has written addr/wdata
        logic                   committed;      // rob retired it, stores only
        logic                   is_store;
        word_t                  addr;
        word_t                  wdata;
        logic   [`PREG_W-1:0]   preg;
        logic   [`ROB_W-1:0]    rob;
    } lsq_entry_t;

    // request from queue head to data memory
    typedef struct packed {
        logic                   is_store;
        word_t                  addr;           // byte address
        word_t                  wdata;
        logic   [`PREG_W-1:0]   preg;           // load destination
    } mem_req_t;

endpackage : lsq_types

// File: lsq_if.sv
// address write path from agu into the queue
interface agu_wb_if
import rv32i_types::*, lsq_types::*;
();

    logic       wb_valid;   // one-cycle strobe
    lsq_idx_t   wb_idx;
    word_t      wb_addr;
    word_t      wb_wdata;
    lsq_idx_t   alloc_idx;  // slot the next enqueue takes

    modport agu (
        output wb_valid,
        output wb_idx,
        output wb_addr,
        output wb_wdata,
        input  alloc_idx
    );

    modport queue (
        input  wb_valid,
        input  wb_idx,
        input  wb_addr,
        input  wb_wdata,
        output alloc_idx
    );

endinterface : agu_wb_if

// head request to data memory, one outstanding at a time
interface mem_req_if
import lsq_types::*;
();

    logic       req_valid;  // one-cycle strobe
    mem_req_t   req;
    logic       done;       // cycle after the request

    modport queue (
        output req_valid,
        output req,
        input  done
    );

    modport mem (
        input  req_valid,
        input  req,
        output done
    );

endinterface : mem_req_if

// File: agu.sv
module agu
import rv32i_types::*, lsq_types::*;
(
    input   logic       clk,
    input   logic       rst,

    // dispatch
    input   logic       enqueue_valid,
    input   opcode_t    opcode,
    input   word_t      base,
    input   word_t      imm,
    input   word_t      store_data,

    // address write into the queue
    agu_wb_if.agu       wb
);

    logic           pend;       // captured dispatch waiting for its write
    lsq_idx_t       slot_q;
    word_t          base_q;
    logic   [11:0]  imm_q;      // I/S-type immediate field
    word_t          data_q;
    logic           store_q;
    word_t          imm_sext;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else begin
            pend <= enqueue_valid;
        end
    end

    // operands ride along with the slot picked at enqueue
    always_ff @(posedge clk) begin
        if (enqueue_valid) begin
            slot_q  <= wb.alloc_idx;
            base_q  <= base;
            imm_q   <= imm[11:0];
            data_q  <= store_data;
            store_q <= (opcode == op_store);
        end
    end

    assign imm_sext = {{20{imm_q[11]}}, imm_q};

    // address add in the cycle after dispatch
    assign wb.wb_valid = pend;
    assign wb.wb_idx   = slot_q;
    assign wb.wb_addr  = base_q + imm_sext;
    assign wb.wb_wdata = store_q ? data_q : '0;  // loads carry no data

endmodule : agu

// File: memory_queue.sv
`include "lsq_defs.svh"

module memory_queue
import rv32i_types::*, lsq_types::*;
(
    input   logic                   clk,
    input   logic                   rst,

    // dispatch
    input   logic                   enqueue_valid,
    input   opcode_t                opcode,
    input   logic   [`PREG_W-1:0]   preg_in,
    input   logic   [`ROB_W-1:0]    rob_in,

    // rob commit
    input   logic                   commit_valid,
    input   logic   [`ROB_W-1:0]    commit_rob,

    output  logic                   full,

    agu_wb_if.queue                 agu,
    mem_req_if.queue                mem
);

    localparam int IDX_W = $bits(lsq_idx_t);

    lsq_entry_t                 entries [`LSQ_DEPTH];
    logic   [IDX_W:0]           head;           // msb is the wrap bit
    logic   [IDX_W:0]           tail;
    lsq_idx_t                   head_idx;
    lsq_idx_t                   tail_idx;
    lsq_entry_t                 head_entry;
    lsq_entry_t                 new_entry;
    logic                       enq_accept;
    logic                       is_store_in;
    logic                       issue;
    logic                       retire;
    logic                       outstanding;    // head sent, waiting for done
    logic   [`LSQ_DEPTH-1:0]    commit_hit;
    logic   [`LSQ_DEPTH-1:0]    addr_hit;

    assign head_idx   = head[IDX_W-1:0];
    assign tail_idx   = tail[IDX_W-1:0];
    assign head_entry = entries[head_idx];

    // same slot, pointers one lap apart
    assign full       = (head_idx == tail_idx) && (head[IDX_W] != tail[IDX_W]);
    assign enq_accept = enqueue_valid && !full;     // enqueue into a full queue is lost

    assign agu.alloc_idx = tail_idx;

    assign is_store_in = (opcode == op_store);

    always_comb begin
        new_entry          = '0;
        new_entry.valid    = 1'b1;
        new_entry.is_store = is_store_in;
        new_entry.preg     = preg_in;
        new_entry.rob      = rob_in;
        // commit strobe in the dispatch cycle itself
        new_entry.committed = is_store_in && commit_valid && (commit_rob == rob_in);
    end

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            commit_hit[i] = commit_valid && entries[i].valid && entries[i].is_store
                            && (entries[i].rob == commit_rob);
            // only a slot still waiting for its address takes the write
            addr_hit[i] = agu.wb_valid && (agu.wb_idx == lsq_idx_t'(i))
                          && entries[i].valid && !entries[i].addr_ready;
        end
    end

    // head goes out once address known and, for a store, committed
    assign issue = head_entry.valid && head_entry.addr_ready
                   && (!head_entry.is_store || head_entry.committed)
                   && !outstanding;

    assign retire = mem.done;

    assign mem.req_valid = issue;
    assign mem.req = '{
        is_store: head_entry.is_store,
        addr:     head_entry.addr,
        wdata:    head_entry.wdata,
        preg:     head_entry.preg
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (issue) begin
            outstanding <= 1'b1;
        end else if (retire) begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (retire) begin
                head <= head + 1'b1;
            end
            if (enq_accept) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // tail slot is never valid on an accepted enqueue, so no update collides with it
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (rst) begin
                entries[i].valid      <= 1'b0;
                entries[i].addr_ready <= 1'b0;
                entries[i].committed  <= 1'b0;
            end else if (enq_accept && (tail_idx == lsq_idx_t'(i))) begin
                entries[i] <= new_entry;
            end else begin
                if (addr_hit[i]) begin
                    entries[i].addr       <= agu.wb_addr;
                    entries[i].wdata      <= agu.wb_wdata;
                    entries[i].addr_ready <= 1'b1;
                end
                if (commit_hit[i]) begin
                    entries[i].committed <= 1'b1;
                end
                if (retire && (head_idx == lsq_idx_t'(i))) begin
                    entries[i].valid <= 1'b0;   // head access finished
                end
            end
        end
    end

endmodule : memory_queue

// File: dmem_port.sv
`include "lsq_defs.svh"

module dmem_port
import rv32i_types::*, lsq_types::*;
(
    input   logic                   clk,
    input   logic                   rst,

    mem_req_if.mem                  mem,

    // load writeback
    output  logic                   wb_valid,
    output  logic   [`PREG_W-1:0]   wb_preg,
    output  word_t                  wb_data
);

    localparam int WORDS = 2 ** `DMEM_AW;

    word_t                  ram [WORDS];
    logic                   pend;       // request taken last edge
    mem_req_t               req_q;
    logic   [`DMEM_AW-1:0]  widx;

    // powers up as zeros
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            ram[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else begin
            pend <= mem.req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.req_valid) begin
            req_q <= mem.req;
        end
    end

    // word index, byte offset dropped
    assign widx = req_q.addr[`DMEM_AW+1:2];

    // store lands at the edge that also sees done
    always_ff @(posedge clk) begin
        if (pend && req_q.is_store) begin
            ram[widx] <= req_q.wdata;
        end
    end

    assign mem.done = pend;

    assign wb_valid = pend && !req_q.is_store;
    assign wb_preg  = req_q.preg;
    assign wb_data  = ram[widx];   // read in the done cycle

endmodule : dmem_port

// File: lsq_top.sv
`include "lsq_defs.svh"

module lsq_top
import rv32i_types::*;
(
    input   logic                   clk,
    input   logic                   rst,

    // dispatch
    input   logic                   enqueue_valid,
    input   opcode_t                opcode,
    input   word_t                  base,
    input   word_t                  imm,
    input   word_t                  store_data,
    input   logic   [`PREG_W-1:0]   preg_in,
    input   logic   [`ROB_W-1:0]    rob_in,

    // rob commit
    input   logic                   commit_valid,
    input   logic   [`ROB_W-1:0]    commit_rob,

    // load writeback
    output  logic                   wb_valid,
    output  logic   [`PREG_W-1:0]   wb_preg,
    output  word_t                  wb_data,
    output  logic                   full
);

    agu_wb_if   agu_wb ();
    mem_req_if  mem_bus ();

    agu u_agu (
        .clk           (clk),
        .rst           (rst),
        .enqueue_valid (enqueue_valid),
        .opcode        (opcode),
        .base          (base),
        .imm           (imm),
        .store_data    (store_data),
        .wb            (agu_wb.agu)
    );

    memory_queue u_memory_queue (
        .clk           (clk),
        .rst           (rst),
        .enqueue_valid (enqueue_valid),
        .opcode        (opcode),
        .preg_in       (preg_in),
        .rob_in        (rob_in),
        .commit_valid  (commit_valid),
        .commit_rob    (commit_rob),
        .full          (full),
        .agu           (agu_wb.queue),
        .mem           (mem_bus.queue)
    );

    dmem_port u_dmem_port (
        .clk           (clk),
        .rst           (rst),
        .mem           (mem_bus.mem),
        .wb_valid      (wb_valid),
        .wb_preg       (wb_preg),
        .wb_data       (wb_data)
    );

endmodule : lsq_top

// File: lsq_props.sv
`include "lsq_defs.svh"

module lsq_props (
    input   logic                           clk,
    input   logic                           rst,
    input   logic                           req_valid,
    input   logic                           done,
    input   logic                           enqueue_valid,
    input   logic                           full,
    input   logic   [$clog2(`LSQ_DEPTH):0]  head,
    input   logic   [$clog2(`LSQ_DEPTH):0]  tail,
    input   logic                           req_is_store,
    input   logic   [`ROB_W-1:0]            req_rob,
    input   logic                           commit_valid,
    input   logic   [`ROB_W-1:0]            commit_rob
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                           in_flight;      // request seen, done not yet
    logic   [$clog2(`LSQ_DEPTH):0]  count;
    logic   [2**`ROB_W-1:0]         rob_committed;  // commits not yet used by a store
    int                             assert_fails = 0;

    assign count = tail - head;

    // tracks the memory handshake from its own strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (req_valid) begin
            in_flight <= 1'b1;
        end else if (done) begin
            in_flight <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rob_committed <= '0;
        end else begin
            if (req_valid && req_is_store) begin
                rob_committed[req_rob] <= 1'b0;
            end
            if (commit_valid) begin
                rob_committed[commit_rob] <= 1'b1;
            end
        end
    end

    // one request in flight at most
    no_req_while_busy: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> !req_valid)
        else begin
            $error("request raised while one is still outstanding");
            assert_fails++;
        end

    // an enqueue against a full queue never grows the count
    full_blocks_enqueue: assert property (@(posedge clk) disable iff (rst)
        (full && enqueue_valid) |=> (count <= $past(count)))
        else begin
            $error("enqueue accepted while the queue was full");
            assert_fails++;
        end

    // a store goes out only after its rob number was committed
    store_needs_commit: assert property (@(posedge clk) disable iff (rst)
        (req_valid && req_is_store) |-> rob_committed[req_rob])
        else begin
            $error("store sent to memory before its commit");
            assert_fails++;
        end

endmodule : lsq_props

bind memory_queue lsq_props props0 (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (issue),
    .done           (retire),
    .enqueue_valid  (enqueue_valid),
    .full           (full),
    .head           (head),
    .tail           (tail),
    .req_is_store   (head_entry.is_store),
    .req_rob        (head_entry.rob),
    .commit_valid   (commit_valid),
    .commit_rob     (commit_rob)
);

// File: tb_lsq.sv
`include "lsq_defs.svh"

module tb_lsq
import rv32i_types::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   enqueue_valid;
    opcode_t                opcode;
    word_t                  base;
    word_t                  imm;
    word_t                  store_data;
    logic   [`PREG_W-1:0]   preg_in;
    logic   [`ROB_W-1:0]    rob_in;
    logic                   commit_valid;
    logic   [`ROB_W-1:0]    commit_rob;
    logic                   wb_valid;
    logic   [`PREG_W-1:0]   wb_preg;
    word_t                  wb_data;
    logic                   full;

    word_t                  model_mem [2 ** `DMEM_AW];
    logic   [`PREG_W-1:0]   exp_preg [$];
    word_t                  exp_data [$];
    logic   [`ROB_W-1:0]    commit_q [$];
    logic   [`PREG_W-1:0]   next_preg;
    logic   [`ROB_W-1:0]    next_rob;
    logic   [`PREG_W-1:0]   e_preg;
    word_t                  e_data;
    logic   [`ROB_W-1:0]    r;
    logic   [`ROB_W-1:0]    load_rob;
    string                  cur_test;
    integer                 seed = 32'hded0b7a7;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     failed = 0;
    int                     e0, lat, held, n, gap, cyc, w, d;

    lsq_top dut0 (.*);

    always #4 clk = ~clk;

    // memory image in program order; a store returns its own data
    function automatic word_t ref_access(input bit st, input word_t addr, input word_t data);
        word_t rd;
        rd = model_mem[addr[`DMEM_AW+1:2]];
        if (st) begin
            model_mem[addr[`DMEM_AW+1:2]] = data;
            rd = data;
        end
        return rd;
    endfunction

    // drive one dispatch; caller sits at a falling edge
    task automatic put_op(input bit st, input word_t b, input word_t i, input word_t dt,
                          output logic [`ROB_W-1:0] rob);
        word_t ex;
        enqueue_valid = 1'b1;
        opcode        = st ? op_store : op_load;
        base          = b;
        imm           = i;
        store_data    = dt;
        preg_in       = next_preg;
        rob_in        = next_rob;
        rob           = next_rob;
        ex = ref_access(st, b + i, dt);
        if (!st) begin
            exp_preg.push_back(next_preg);
            exp_data.push_back(ex);
        end
        next_preg++;
        next_rob++;
    endtask

    task automatic step();
        @(negedge clk);
        enqueue_valid = 1'b0;
        commit_valid  = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int k;
        k = 0;
        while (exp_preg.size() != 0 && k < limit) begin
            @(posedge clk);     // queue is only popped on falling edges
            k++;
        end
        if (exp_preg.size() != 0) begin
            $display("%s: %0d load writebacks missing after %0d cycles",
                     cur_test, exp_preg.size(), limit);
            errors++;
            exp_preg.delete();
            exp_data.delete();
        end
        @(negedge clk);
    endtask

    task automatic end_test(input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - err_before);
            failed++;
        end
    endtask

    // compare process samples writebacks on the falling edge
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_preg.size() == 0) begin
                $display("%s: writeback with nothing expected, preg %0d data %h",
                         cur_test, wb_preg, wb_data);
                errors++;
            end else begin
                e_preg = exp_preg.pop_front();
                e_data = exp_data.pop_front();
                checks += 2;
                if (wb_preg !== e_preg) begin
                    $display("FAIL %s preg expected %0d actual %0d", cur_test, e_preg, wb_preg);
                    errors++;
                end
                if (wb_data !== e_data) begin
                    $display("FAIL %s data expected %h actual %h", cur_test, e_data, wb_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        enqueue_valid = 1'b0;
        opcode = op_load;
        base = '0;
        imm = '0;
        store_data = '0;
        preg_in = '0;
        rob_in = '0;
        commit_valid = 1'b0;
        commit_rob = '0;
        next_preg = '0;
        next_rob = '0;
        cur_test = "reset";
        for (int i = 0; i < 2 ** `DMEM_AW; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        repeat (10) begin
            @(negedge clk);
            checks++;
            if (full || wb_valid) begin
                $display("%s: full or wb_valid high while idle", cur_test);
                errors++;
            end
        end
        end_test(e0);

        // store committed at dispatch, then a load from the same word
        cur_test = "store_load";
        e0 = errors;
        put_op(1, 32'h100, 32'h10, 32'hcafe0001, r);
        commit_valid = 1'b1;
        commit_rob   = r;
        step();
        put_op(0, 32'h118, 32'hffff_fff8, 32'h0, r);
        step();
        lat = 1;
        while (!wb_valid && lat < 40) begin
            @(negedge clk);
            lat++;
        end
        checks++;
        if (!wb_valid) begin
            $display("%s: load never wrote back", cur_test);
            errors++;
        end else if (lat < 4) begin
            $display("FAIL %s latency expected >= 4 actual %0d", cur_test, lat);
            errors++;
        end
        wait_drain(50);
        end_test(e0);

        cur_test = "commit_order";
        e0 = errors;
        put_op(1, 32'h140, 32'h0, 32'h1234abcd, r);
        step();
        put_op(0, 32'h13c, 32'h4, 32'h0, load_rob);
        step();
        repeat (30) begin
            @(negedge clk);
            checks++;
            if (wb_valid) begin
                $display("%s: load wrote back before its older store committed", cur_test);
                errors++;
            end
        end
        commit_valid = 1'b1;
        commit_rob   = r;
        step();
        wait_drain(50);
        end_test(e0);

        cur_test = "full_flag";
        e0 = errors;
        put_op(1, 32'h300, 32'h0, 32'h5a5a0004, r);
        step();
        for (held = 1; held <= `LSQ_DEPTH; held++) begin
            checks++;
            if (full !== (held == `LSQ_DEPTH)) begin
                $display("FAIL %s full at %0d entries expected %0d actual %0d",
                         cur_test, held, held == `LSQ_DEPTH, full);
                errors++;
            end
            if (held < `LSQ_DEPTH) begin
                put_op(0, 32'h300, word_t'(4 * (held % 2)), 32'h0, load_rob);
                step();
            end
        end
        // one more load while full is dropped
        enqueue_valid = 1'b1;
        opcode        = op_load;
        preg_in       = next_preg;
        rob_in        = next_rob;
        step();
        checks++;
        if (!full) begin
            $display("%s: enqueue into a full queue was taken", cur_test);
            errors++;
        end
        commit_valid = 1'b1;
        commit_rob   = r;
        step();
        n = 0;
        while (full && n < 20) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (full) begin
            $display("%s: full stayed high after the commit", cur_test);
            errors++;
        end
        wait_drain(200);
        end_test(e0);

        // random loads and stores over 16 words with stores committed in order
        cur_test = "random_mix";
        e0 = errors;
        n = 0;
        gap = 0;
        for (cyc = 0; cyc < 20000 && (n < 200 || commit_q.size() > 0); cyc++) begin
            if (n < 200 && !full && ($random(seed) & 3) != 0) begin
                w = $random(seed) & 15;
                d = $random(seed) & 7;
                if ($random(seed) & 1) begin
                    put_op(1, 32'h180 + 4 * (w + d), -4 * d, $random(seed), r);
                    commit_q.push_back(r);
                end else begin
                    put_op(0, 32'h180 + 4 * (w + d), -4 * d, 32'h0, r);
                end
                n++;
            end
            if (commit_q.size() > 0) begin
                if (gap == 0) begin
                    commit_valid = 1'b1;
                    commit_rob   = commit_q.pop_front();
                    gap = ($random(seed) & 32'h7fff_ffff) % 6;
                end else begin
                    gap--;
                end
            end
            step();
        end
        if (n < 200 || commit_q.size() > 0) begin
            $display("%s: stimulus stalled after %0d of 200 ops", cur_test, n);
            errors++;
        end
        wait_drain(2000);
        end_test(e0);

        errors += dut0.u_memory_queue.props0.assert_fails;
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_lsq

// File: lsq_top.f
+incdir+.
rv32i_types.sv
lsq_types.sv
lsq_if.sv
agu.sv
memory_queue.sv
dmem_port.sv
lsq_top.sv
lsq_props.sv
tb_lsq.sv
